//--- project.f
+incdir+rtl
rtl/apbSysPkg.sv
rtl/ahbApbBridge.sv
rtl/apbSlotMux.sv
rtl/prescaledCounter.sv
rtl/timerUnit.sv
rtl/pwmUnit.sv
rtl/apbSys.sv
sim/apbSys_chk.sv
sim/apbSysTb.sv

//--- rtl/ahbApbBridge.sv
`timescale 1ns/1ps

module ahbApbBridge import apbSysPkg::*; (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL_i,
    input  word_t       HADDR_i,
    input  logic [1:0]  HTRANS_i,
    input  logic        HWRITE_i,
    input  word_t       HWDATA_i,
    input  logic        HREADY_i,
    output word_t       HRDATA_o,
    output logic        HREADYOUT_o,
    output word_t       paddr_o,
    output word_t       pwdata_o,
    output logic        pwrite_o,
    output logic        psel_o,
    output logic        penable_o,
    input  word_t       prdata_i,
    input  logic        pready_i
);
    bridgeState_t state;
    bridgeState_t nextState;

    logic  accept;
    logic  accessDone;
    logic  newXfer;
    word_t addrReg;
    word_t dataReg;
    logic  writeReg;

    // NONSEQ or SEQ to this slave while the bus is ready
    assign accept = HSEL_i & HREADY_i & HTRANS_i[1];

    assign accessDone = (state == ACCESS) & pready_i;

    // A new address phase lands in IDLE or in the last ACCESS cycle
    assign newXfer = accept & ((state == IDLE) | accessDone);

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (accept) begin
                    nextState = CAPTURE;
                end
            end
            CAPTURE: begin
                nextState = SETUP;
            end
            SETUP: begin
                nextState = ACCESS;
            end
            ACCESS: begin
                if (pready_i) begin
                    nextState = accept ? CAPTURE : IDLE;
                end
            end
            default: begin
                nextState = IDLE;
            end
        endcase
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            state <= IDLE;
        end else begin
            state <= nextState;
        end
    end

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            writeReg <= 1'b0;
        end else if (newXfer) begin
            writeReg <= HWRITE_i;
        end
    end

    // Address held for the whole APB sequence
    always_ff @(posedge HCLK) begin
        if (newXfer) begin
            addrReg <= HADDR_i;
        end
    end

    // Write data arrives one cycle after the address phase
    always_ff @(posedge HCLK) begin
        if (state == CAPTURE) begin
            dataReg <= HWDATA_i;
        end
    end

    assign paddr_o   = addrReg;
    assign pwdata_o  = dataReg;
    assign pwrite_o  = writeReg;
    assign psel_o    = (state == SETUP) | (state == ACCESS);
    assign penable_o = (state == ACCESS);

    // Stall the AHB data phase until the APB access completes
    assign HREADYOUT_o = ~((state == CAPTURE) | (state == SETUP) |
                           ((state == ACCESS) & ~pready_i));

    assign HRDATA_o = prdata_i;

endmodule

//--- rtl/apbSlotMux.sv
`timescale 1ns/1ps
`include "apbSys_defs.svh"

module apbSlotMux import apbSysPkg::*; (
    input  word_t  paddr_i,
    input  logic   psel_i,
    output logic   timerSel_o,
    output logic   pwmSel_o,
    input  word_t  timerRdata_i,
    input  word_t  pwmRdata_i,
    output word_t  prdata_o,
    output logic   pready_o
);
    slotIdx_t slot;

    assign slot = paddr_i[`SLOT_MSB:`SLOT_LSB];

    assign timerSel_o = psel_i & (slot == `SLOT_TIMER);
    assign pwmSel_o   = psel_i & (slot == `SLOT_PWM);

    // Unmapped slots read as zero
    always_comb begin
        case (slot)
            `SLOT_TIMER: begin
                prdata_o = timerRdata_i;
            end
            `SLOT_PWM: begin
                prdata_o = pwmRdata_i;
            end
            default: begin
                prdata_o = '0;
            end
        endcase
    end

    // Both peripherals and the empty slots finish in one access cycle
    assign pready_o = 1'b1;

endmodule

//--- rtl/apbSys.sv
`timescale 1ns/1ps
`include "apbSys_defs.svh"

module apbSys import apbSysPkg::*; (
    input  logic        HCLK,
    input  logic        HRESETn,
    input  logic        HSEL_i,
    input  word_t       HADDR_i,
    input  logic [1:0]  HTRANS_i,
    input  logic        HWRITE_i,
    input  word_t       HWDATA_i,
    input  logic        HREADY_i,
    output word_t       HRDATA_o,
    output logic        HREADYOUT_o,
    output logic        timerIrq_o,
    output logic        pwm_o
);
    // APB side of the bridge
    word_t paddr;
    word_t pwdata;
    word_t prdata;
    logic  pwrite;
    logic  psel;
    logic  penable;
    logic  pready;

    // Per-slot selects and read data
    logic  timerSel;
    logic  pwmSel;
    word_t timerRdata;
    word_t pwmRdata;

    ahbApbBridge i_bridge (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .HSEL_i      (HSEL_i),
        .HADDR_i     (HADDR_i),
        .HTRANS_i    (HTRANS_i),
        .HWRITE_i    (HWRITE_i),
        .HWDATA_i    (HWDATA_i),
        .HREADY_i    (HREADY_i),
        .HRDATA_o    (HRDATA_o),
        .HREADYOUT_o (HREADYOUT_o),
        .paddr_o     (paddr),
        .pwdata_o    (pwdata),
        .pwrite_o    (pwrite),
        .psel_o      (psel),
        .penable_o   (penable),
        .prdata_i    (prdata),
        .pready_i    (pready)
    );

    apbSlotMux i_slotMux (
        .paddr_i      (paddr),
        .psel_i       (psel),
        .timerSel_o   (timerSel),
        .pwmSel_o     (pwmSel),
        .timerRdata_i (timerRdata),
        .pwmRdata_i   (pwmRdata),
        .prdata_o     (prdata),
        .pready_o     (pready)
    );

    timerUnit i_timer (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .sel_i     (timerSel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .regIdx_i  (paddr[`REG_MSB:`REG_LSB]),
        .pwdata_i  (pwdata),
        .prdata_o  (timerRdata),
        .irq_o     (timerIrq_o)
    );

    pwmUnit i_pwm (
        .HCLK      (HCLK),
        .HRESETn   (HRESETn),
        .sel_i     (pwmSel),
        .penable_i (penable),
        .pwrite_i  (pwrite),
        .regIdx_i  (paddr[`REG_MSB:`REG_LSB]),
        .pwdata_i  (pwdata),
        .prdata_o  (pwmRdata),
        .pwm_o     (pwm_o)
    );

endmodule

//--- rtl/apbSysPkg.sv
`include "apbSys_defs.svh"

package apbSysPkg;

    // Data and address word
    typedef logic [`DATA_W-1:0] word_t;

    // Slot number from the address decode field
    typedef logic [`SLOT_MSB-`SLOT_LSB:0] slotIdx_t;

    // Register index inside a slot
    typedef logic [`REG_MSB-`REG_LSB:0] regIdx_t;

    typedef enum logic [1:0] {
        IDLE,
        CAPTURE,
        SETUP,
        ACCESS
    } bridgeState_t;

endpackage

//--- rtl/apbSys_defs.svh
`ifndef APBSYS_DEFS_SVH
`define APBSYS_DEFS_SVH

// Bus and register width
`define DATA_W      32

// Address field that picks the APB slot
`define SLOT_MSB    23
`define SLOT_LSB    20

// Word index inside a slot
`define REG_MSB     4
`define REG_LSB     2

`define SLOT_TIMER  4'd0
`define SLOT_PWM    4'd1

// Timer register map
`define TMR_CNT     3'd0
`define TMR_PRE     3'd1
`define TMR_CMP     3'd2
`define TMR_OVF     3'd3
`define TMR_EN      3'd4
`define TMR_IRQEN   3'd5

// PWM register map
`define PWM_PRE     3'd0
`define PWM_PERIOD  3'd1
`define PWM_DUTY    3'd2
`define PWM_EN      3'd3

`endif

//--- rtl/prescaledCounter.sv
`timescale 1ns/1ps

module prescaledCounter import apbSysPkg::*; (
    input  logic   HCLK,
    input  logic   HRESETn,
    input  logic   enable_i,
    input  word_t  pre_i,
    input  word_t  cmp_i,
    output word_t  count_o,
    output logic   wrap_o
);
    word_t preCnt;
    logic  tick;
    logic  atCmp;

    // Catches a prescale value lowered below the running count too
    assign tick  = enable_i & (preCnt >= pre_i);
    assign atCmp = (count_o == cmp_i);

    assign wrap_o = tick & atCmp;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preCnt  <= '0;
            count_o <= '0;
        end else if (!enable_i) begin
            preCnt  <= '0;
            count_o <= '0;
        end else if (tick) begin
            preCnt  <= '0;
            count_o <= atCmp ? '0 : count_o + 1'b1;
        end else begin
            preCnt <= preCnt + 1'b1;
        end
    end

endmodule

//--- rtl/pwmUnit.sv
`timescale 1ns/1ps
`include "apbSys_defs.svh"

module pwmUnit import apbSysPkg::*; (
    input  logic     HCLK,
    input  logic     HRESETn,
    input  logic     sel_i,
    input  logic     penable_i,
    input  logic     pwrite_i,
    input  regIdx_t  regIdx_i,
    input  word_t    pwdata_i,
    output word_t    prdata_o,
    output logic     pwm_o
);
    word_t preReg;
    word_t periodReg;
    word_t dutyReg;
    word_t count;
    logic  enReg;
    logic  wrEn;

    assign wrEn = sel_i & penable_i & pwrite_i;

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preReg    <= '0;
            periodReg <= '0;
            dutyReg   <= '0;
            enReg     <= 1'b0;
        end else if (wrEn) begin
            case (regIdx_i)
                `PWM_PRE:    preReg    <= pwdata_i;
                `PWM_PERIOD: periodReg <= pwdata_i;
                `PWM_DUTY:   dutyReg   <= pwdata_i;
                `PWM_EN:     enReg     <= pwdata_i[0];
                default: ;
            endcase
        end
    end

    // Period end comes from the count itself
    prescaledCounter i_counter (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .enable_i (enReg),
        .pre_i    (preReg),
        .cmp_i    (periodReg),
        .count_o  (count),
        .wrap_o   ()
    );

    // High for the first DUTY counts of each period
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            pwm_o <= 1'b0;
        end else begin
            pwm_o <= enReg & (count < dutyReg);
        end
    end

    always_comb begin
        case (regIdx_i)
            `PWM_PRE:    prdata_o = preReg;
            `PWM_PERIOD: prdata_o = periodReg;
            `PWM_DUTY:   prdata_o = dutyReg;
            `PWM_EN:     prdata_o = {{(`DATA_W-1){1'b0}}, enReg};
            default:     prdata_o = '0;
        endcase
    end

endmodule

//--- rtl/timerUnit.sv
`timescale 1ns/1ps
`include "apbSys_defs.svh"

module timerUnit import apbSysPkg::*; (
    input  logic     HCLK,
    input  logic     HRESETn,
    input  logic     sel_i,
    input  logic     penable_i,
    input  logic     pwrite_i,
    input  regIdx_t  regIdx_i,
    input  word_t    pwdata_i,
    output word_t    prdata_o,
    output logic     irq_o
);
    word_t preReg;
    word_t cmpReg;
    word_t count;
    logic  enReg;
    logic  irqEnReg;
    logic  ovfFlag;
    logic  wrap;
    logic  wrEn;
    logic  ovfClr;

    assign wrEn   = sel_i & penable_i & pwrite_i;
    assign ovfClr = wrEn & (regIdx_i == `TMR_OVF) & pwdata_i[0];

    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            preReg   <= '0;
            cmpReg   <= '0;
            enReg    <= 1'b0;
            irqEnReg <= 1'b0;
        end else if (wrEn) begin
            case (regIdx_i)
                `TMR_PRE:   preReg   <= pwdata_i;
                `TMR_CMP:   cmpReg   <= pwdata_i;
                `TMR_EN:    enReg    <= pwdata_i[0];
                `TMR_IRQEN: irqEnReg <= pwdata_i[0];
                default: ;
            endcase
        end
    end

    // New wrap beats a clear in the same cycle
    always_ff @(posedge HCLK or negedge HRESETn) begin
        if (!HRESETn) begin
            ovfFlag <= 1'b0;
        end else if (wrap) begin
            ovfFlag <= 1'b1;
        end else if (ovfClr) begin
            ovfFlag <= 1'b0;
        end
    end

    prescaledCounter i_counter (
        .HCLK     (HCLK),
        .HRESETn  (HRESETn),
        .enable_i (enReg),
        .pre_i    (preReg),
        .cmp_i    (cmpReg),
        .count_o  (count),
        .wrap_o   (wrap)
    );

    always_comb begin
        case (regIdx_i)
            `TMR_CNT:   prdata_o = count;
            `TMR_PRE:   prdata_o = preReg;
            `TMR_CMP:   prdata_o = cmpReg;
            `TMR_OVF:   prdata_o = {{(`DATA_W-1){1'b0}}, ovfFlag};
            `TMR_EN:    prdata_o = {{(`DATA_W-1){1'b0}}, enReg};
            `TMR_IRQEN: prdata_o = {{(`DATA_W-1){1'b0}}, irqEnReg};
            default:    prdata_o = '0;
        endcase
    end

    assign irq_o = ovfFlag & irqEnReg;

endmodule

//--- run.sh
#!/bin/sh
# Build and run the APB subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module apbSysTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -q "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- sim/apbSysTb.sv
`timescale 1ns/1ps
`include "apbSys_defs.svh"

module apbSysTb import apbSysPkg::*; ();

    // Four cycles per bus transfer plus the timer and PWM waits, with wide margin
    localparam int MAX_CYCLES = 20000;

    logic        HCLK;
    logic        HRESETn;
    logic        HSEL;
    word_t       HADDR;
    logic [1:0]  HTRANS;
    logic        HWRITE;
    word_t       HWDATA;
    logic        HREADY;
    word_t       HRDATA;
    logic        HREADYOUT;
    logic        timerIrq;
    logic        pwm;

    logic [31:0] lfsr;
    int          cycles;
    int          irqCycle;
    logic        irqSeen;
    logic        runDone;
    logic        failShown;
    word_t       tmrRegs [0:7];
    word_t       pwmRegs [0:7];

    apbSys i_dut (
        .HCLK        (HCLK),
        .HRESETn     (HRESETn),
        .HSEL_i      (HSEL),
        .HADDR_i     (HADDR),
        .HTRANS_i    (HTRANS),
        .HWRITE_i    (HWRITE),
        .HWDATA_i    (HWDATA),
        .HREADY_i    (HREADY),
        .HRDATA_o    (HRDATA),
        .HREADYOUT_o (HREADYOUT),
        .timerIrq_o  (timerIrq),
        .pwm_o       (pwm)
    );

    initial begin
        HCLK = 1'b0;
        forever #5 HCLK = ~HCLK;
    end

    initial begin
        cycles = 0;
        forever begin
            @(posedge HCLK);
            cycles++;
            if (cycles > MAX_CYCLES) begin
                failShown = 1'b1;
                $display("Timeout: the run did not finish within %0d clock cycles", MAX_CYCLES);
                $display("TESTS FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    // First cycle at which the interrupt is seen
    always @(negedge HCLK) begin
        if (timerIrq && !irqSeen) begin
            irqSeen  = 1'b1;
            irqCycle = cycles;
        end
    end

    final begin
        if (!runDone && !failShown) begin
            $display("TESTS FAILED");
        end
    end

    // Galois LFSR stepped once per bit
    function automatic word_t randBits(input int n);
        word_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic word_t regAddr(input slotIdx_t slot, input regIdx_t idx);
        word_t a;
        a = '0;
        a[`SLOT_MSB:`SLOT_LSB] = slot;
        a[`REG_MSB:`REG_LSB] = idx;
        return a;
    endfunction

    task automatic checkEq(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            failShown = 1'b1;
            $display("[FAIL] %0t: %s: got %0h, expected %0h", $time, what, got, exp);
            $display("TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // Single NONSEQ transfer between two falling edges
    task automatic busXfer(input logic wr, input word_t addr, input word_t wdata,
                           output word_t rdata);
        int stall;
        stall  = 0;
        HSEL   = 1'b1;
        HADDR  = addr;
        HTRANS = 2'b10;
        HWRITE = wr;
        @(negedge HCLK);
        HSEL   = 1'b0;
        HTRANS = 2'b00;
        HWDATA = wdata;
        while (!HREADYOUT) begin
            stall++;
            @(negedge HCLK);
        end
        rdata = HRDATA;
        checkEq(word_t'(stall), 2, "data phase wait cycles");
    endtask

    task automatic ahbWrite(input word_t addr, input word_t data);
        word_t unused;
        busXfer(1'b1, addr, data, unused);
    endtask

    task automatic ahbRead(input word_t addr, output word_t data);
        busXfer(1'b0, addr, '0, data);
    endtask

    task automatic writeReg(input slotIdx_t slot, input regIdx_t idx, input word_t data);
        ahbWrite(regAddr(slot, idx), data);
        // Enable bits keep only bit 0
        if (slot == `SLOT_TIMER) begin
            tmrRegs[idx] = (idx == `TMR_EN || idx == `TMR_IRQEN) ? {31'b0, data[0]} : data;
        end else begin
            pwmRegs[idx] = (idx == `PWM_EN) ? {31'b0, data[0]} : data;
        end
    endtask

    task automatic expectReg(input slotIdx_t slot, input regIdx_t idx, input string what);
        word_t rd;
        ahbRead(regAddr(slot, idx), rd);
        checkEq(rd, (slot == `SLOT_TIMER) ? tmrRegs[idx] : pwmRegs[idx], what);
    endtask

    task automatic waitFall();
        logic prev;
        prev = pwm;
        @(negedge HCLK);
        while (!(prev && !pwm)) begin
            prev = pwm;
            @(negedge HCLK);
        end
    endtask

    // Falling edge to falling edge
    task automatic measurePeriod(output int total, output int high);
        logic prev;
        total = 0;
        high  = 0;
        do begin
            prev = pwm;
            @(negedge HCLK);
            total++;
            if (pwm) begin
                high++;
            end
        end while (!(prev && !pwm));
    endtask

    initial begin
        word_t rd;
        int    r;
        int    s;
        int    pre;
        int    cmp;
        int    limit;
        int    start;
        int    per;
        int    duty;
        int    total;
        int    high;
        lfsr      = 32'h603dee63;
        irqSeen   = 1'b0;
        irqCycle  = 0;
        runDone   = 1'b0;
        failShown = 1'b0;
        for (r = 0; r < 8; r++) begin
            tmrRegs[r] = '0;
            pwmRegs[r] = '0;
        end
        HRESETn = 1'b0;
        HSEL    = 1'b0;
        HADDR   = '0;
        HTRANS  = 2'b00;
        HWRITE  = 1'b0;
        HWDATA  = '0;
        HREADY  = 1'b1;
        repeat (5) @(negedge HCLK);
        HRESETn = 1'b1;

        checkEq(word_t'(HREADYOUT), 1, "HREADYOUT after reset");
        checkEq(word_t'(timerIrq), 0, "timer irq after reset");
        checkEq(word_t'(pwm), 0, "pwm after reset");

        for (r = 0; r < 8; r++) begin
            writeReg(`SLOT_TIMER, `TMR_PRE, randBits(32));
            writeReg(`SLOT_TIMER, `TMR_CMP, randBits(32));
            writeReg(`SLOT_TIMER, `TMR_IRQEN, randBits(32));
            writeReg(`SLOT_PWM, `PWM_PRE, randBits(32));
            writeReg(`SLOT_PWM, `PWM_PERIOD, randBits(32));
            writeReg(`SLOT_PWM, `PWM_DUTY, randBits(32));
            expectReg(`SLOT_TIMER, `TMR_PRE, "timer PRE readback");
            expectReg(`SLOT_TIMER, `TMR_CMP, "timer CMP readback");
            expectReg(`SLOT_TIMER, `TMR_IRQEN, "timer IRQEN readback");
            expectReg(`SLOT_PWM, `PWM_PRE, "pwm PRE readback");
            expectReg(`SLOT_PWM, `PWM_PERIOD, "pwm PERIOD readback");
            expectReg(`SLOT_PWM, `PWM_DUTY, "pwm DUTY readback");
        end
        for (s = 2; s < 16; s++) begin
            ahbRead(regAddr(slotIdx_t'(s), regIdx_t'(randBits(3))), rd);
            checkEq(rd, 0, "unmapped slot read");
        end

        pre   = randBits(2);
        cmp   = 2 + randBits(3);
        limit = (pre + 1) * (cmp + 1) + 8;
        writeReg(`SLOT_TIMER, `TMR_PRE, pre);
        writeReg(`SLOT_TIMER, `TMR_CMP, cmp);
        writeReg(`SLOT_TIMER, `TMR_IRQEN, 1);
        irqSeen = 1'b0;
        writeReg(`SLOT_TIMER, `TMR_EN, 1);
        start = cycles;
        while (!irqSeen && (cycles - start) <= limit) begin
            ahbRead(regAddr(`SLOT_TIMER, `TMR_CNT), rd);
            checkEq(word_t'(rd <= cmp), 1, "timer count not above CMP");
        end
        checkEq(word_t'(irqSeen), 1, "timer irq raised");
        checkEq(word_t'((irqCycle - start) <= limit), 1, "timer irq latency");
        writeReg(`SLOT_TIMER, `TMR_EN, 0);
        ahbWrite(regAddr(`SLOT_TIMER, `TMR_OVF), 1);
        ahbRead(regAddr(`SLOT_TIMER, `TMR_OVF), rd);
        checkEq(rd, 0, "OVF after clear");
        checkEq(word_t'(timerIrq), 0, "timer irq after clear");

        pre  = randBits(4) % 3;
        per  = 3 + randBits(4) % 13;
        duty = randBits(4) % (per + 1);
        writeReg(`SLOT_PWM, `PWM_PRE, pre);
        writeReg(`SLOT_PWM, `PWM_PERIOD, per);
        writeReg(`SLOT_PWM, `PWM_DUTY, duty);
        writeReg(`SLOT_PWM, `PWM_EN, 1);
        if (duty == 0) begin
            repeat (2 * (per + 1) * (pre + 1)) begin
                @(negedge HCLK);
                checkEq(word_t'(pwm), 0, "pwm low at zero duty");
            end
        end else begin
            waitFall();
            waitFall();
            measurePeriod(total, high);
            checkEq(word_t'(total), (per + 1) * (pre + 1), "pwm period length");
            checkEq(word_t'(high), duty * (pre + 1), "pwm high cycles");
        end

        runDone = 1'b1;
        $display("TESTS PASSED");
        $finish;
    end

endmodule

//--- sim/apbSys_chk.sv
`timescale 1ns/1ps

module bridgeChk import apbSysPkg::*; (
    input logic         HCLK,
    input logic         HRESETn,
    input bridgeState_t state_i,
    input logic         psel_i,
    input logic         penable_i,
    input logic         hreadyOut_i,
    input word_t        paddr_i
);
    // Access only after a fresh setup cycle
    assert property (@(posedge HCLK) disable iff (!HRESETn)
        $rose(penable_i) |-> ($past(state_i) == SETUP) && $past(psel_i) &&
                             !$past(penable_i) && !$past(psel_i, 2))
        else $error("penable rose without a setup cycle that raised psel");

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        (psel_i && $past(psel_i)) |-> $stable(paddr_i))
        else $error("paddr changed while psel was high");

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        (state_i == IDLE) |-> hreadyOut_i)
        else $error("HREADYOUT low while the bridge is idle");

    assert property (@(posedge HCLK) disable iff (!HRESETn)
        penable_i |-> psel_i)
        else $error("penable high without psel");

endmodule

bind ahbApbBridge bridgeChk i_bridgeChk (
    .HCLK        (HCLK),
    .HRESETn     (HRESETn),
    .state_i     (state),
    .psel_i      (psel_o),
    .penable_i   (penable_o),
    .hreadyOut_i (HREADYOUT_o),
    .paddr_i     (paddr_o)
);
